// File: rtl/snn_defines.svh
//--------------------------------------
// SNN core sizing
// Array sizes, field widths and the
// LED heartbeat tap
//--------------------------------------
`ifndef SNN_DEFINES_SVH
`define SNN_DEFINES_SVH

// Array sizes
`define SNN_NUM_NEURONS    16
`define SNN_NUM_AXONS      16

// Field widths
`define SNN_NEURON_ID_W    4
`define SNN_AXON_ID_W      4
`define SNN_WEIGHT_W       8
`define SNN_MEMBRANE_W     16
`define SNN_LEAK_W         8
`define SNN_REFRAC_W       4

// Output queue and status
`define SNN_FIFO_DEPTH     8
`define SNN_HEARTBEAT_BIT  10

`endif

// File: rtl/snn_pkg.sv
//--------------------------------------
// SNN core types
// Vector typedefs shared by the blocks
// and the synapse scanner states
//--------------------------------------
`include "snn_defines.svh"

package snn_pkg;

    // Identifiers
    typedef logic [`SNN_NEURON_ID_W-1:0] neuron_id_t;
    typedef logic [`SNN_AXON_ID_W-1:0]   axon_id_t;

    // Synaptic weight, two's complement
    typedef logic signed [`SNN_WEIGHT_W-1:0] weight_t;

    // Neuron state and parameters
    typedef logic [`SNN_MEMBRANE_W-1:0] membrane_t;
    typedef logic [`SNN_LEAK_W-1:0]     leak_t;
    typedef logic [`SNN_REFRAC_W-1:0]   refrac_t;

    // Emitted spike counter
    typedef logic [31:0] spike_count_t;

    // Synapse row scanner
    typedef enum logic {
        scan_idle,
        scan_run
    } scan_state_t;

endpackage

// File: rtl/synapse_array.sv
//--------------------------------------
// Synapse array
// Writable axon x neuron weight table
// and a scanner that fans one axon spike
// out to its nonzero-weight neurons
//--------------------------------------
`timescale 1ns/1ps
`include "snn_defines.svh"

module synapse_array (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                snn_enable,
    input  logic                snn_soft_reset,
    // Weight write port
    input  logic                weight_we,
    input  snn_pkg::axon_id_t   weight_axon,
    input  snn_pkg::neuron_id_t weight_neuron,
    input  snn_pkg::weight_t    weight_data,
    // Input spike
    input  logic                spike_in_valid,
    input  snn_pkg::axon_id_t   spike_in_axon,
    output logic                spike_in_ready,
    // Weighted events toward the neurons
    output logic                syn_event_valid,
    output snn_pkg::neuron_id_t syn_event_neuron,
    output snn_pkg::weight_t    syn_event_weight,
    input  logic                syn_event_ready,
    output logic                scan_busy
);

    import snn_pkg::*;

    localparam int TABLE_SIZE = `SNN_NUM_AXONS * `SNN_NUM_NEURONS;

    // Row-major table, index is {axon, neuron}
    weight_t     weight_mem [TABLE_SIZE];

    scan_state_t scan_state;
    axon_id_t    scan_axon;
    neuron_id_t  scan_neuron;
    weight_t     cur_weight;
    logic        spike_accept;
    logic        scan_advance;
    logic        scan_last;

    //--------------------------------------
    // Weight table
    //--------------------------------------
    // Soft reset keeps the weights
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                weight_mem[i] <= '0;
            end
        end else if (weight_we) begin
            weight_mem[{weight_axon, weight_neuron}] <= weight_data;
        end
    end

    //--------------------------------------
    // Row scanner
    //--------------------------------------
    assign cur_weight   = weight_mem[{scan_axon, scan_neuron}];
    assign spike_accept = spike_in_valid && spike_in_ready;

    // Zero weights pass straight through, others wait for the neurons
    assign scan_advance = (scan_state == scan_run) &&
                          ((cur_weight == '0) || syn_event_ready);
    assign scan_last    = (scan_neuron == neuron_id_t'(`SNN_NUM_NEURONS - 1));

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || snn_soft_reset) begin
            scan_state  <= scan_idle;
            scan_axon   <= '0;
            scan_neuron <= '0;
        end else begin
            case (scan_state)
                scan_idle: begin
                    if (spike_accept) begin
                        scan_axon   <= spike_in_axon;
                        scan_neuron <= '0;
                        scan_state  <= scan_run;
                    end
                end
                scan_run: begin
                    if (scan_advance) begin
                        scan_neuron <= scan_neuron + 1'b1;
                        if (scan_last) begin
                            scan_state <= scan_idle;
                        end
                    end
                end
                default: scan_state <= scan_idle;
            endcase
        end
    end

    assign spike_in_ready   = (scan_state == scan_idle) && snn_enable;
    assign scan_busy        = (scan_state == scan_run);

    assign syn_event_valid  = (scan_state == scan_run) && (cur_weight != '0);
    assign syn_event_neuron = scan_neuron;
    assign syn_event_weight = cur_weight;

endmodule

// File: rtl/lif_neuron_array.sv
//--------------------------------------
// LIF neuron array
// Membrane and refractory state for all
// neurons with integrate, leak and fire
//--------------------------------------
`timescale 1ns/1ps
`include "snn_defines.svh"

module lif_neuron_array (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  snn_enable,
    input  logic                  snn_soft_reset,
    input  logic                  timestep,
    // Global neuron parameters
    input  snn_pkg::membrane_t    threshold,
    input  snn_pkg::leak_t        leak_rate,
    input  snn_pkg::refrac_t      refrac_period,
    // Events from the synapse array
    input  logic                  syn_event_valid,
    input  snn_pkg::neuron_id_t   syn_event_neuron,
    input  snn_pkg::weight_t      syn_event_weight,
    output logic                  syn_event_ready,
    // Fired spikes toward the output queue
    output logic                  fire_valid,
    output snn_pkg::neuron_id_t   fire_neuron,
    input  logic                  fifo_full,
    output snn_pkg::spike_count_t spike_count
);

    import snn_pkg::*;

    localparam int MEM_W = `SNN_MEMBRANE_W;

    membrane_t membrane [`SNN_NUM_NEURONS];
    refrac_t   refrac   [`SNN_NUM_NEURONS];

    logic      leak_step;
    logic      event_accept;
    logic      event_live;
    membrane_t next_mem;

    // Leak owns the cycle, events wait behind it and behind a full queue
    assign leak_step       = timestep && snn_enable;
    assign syn_event_ready = !fifo_full && !leak_step;
    assign event_accept    = syn_event_valid && syn_event_ready;

    // Refractory neurons drop their events
    assign event_live = event_accept && (refrac[syn_event_neuron] == '0);

    //--------------------------------------
    // Integrate with saturation
    //--------------------------------------
    always_comb begin
        logic signed [MEM_W+1:0] sum;

        sum = $signed({2'b00, membrane[syn_event_neuron]}) + syn_event_weight;
        if (sum < 0) begin
            next_mem = '0;
        end else if (sum[MEM_W]) begin
            // Above the largest membrane value
            next_mem = '1;
        end else begin
            next_mem = sum[MEM_W-1:0];
        end
    end

    // Fire in the same edge as the update that crosses threshold
    assign fire_valid  = event_live && (next_mem >= threshold);
    assign fire_neuron = syn_event_neuron;

    //--------------------------------------
    // Neuron state
    //--------------------------------------
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || snn_soft_reset) begin
            for (int i = 0; i < `SNN_NUM_NEURONS; i++) begin
                membrane[i] <= '0;
                refrac[i]   <= '0;
            end
        end else if (leak_step) begin
            for (int i = 0; i < `SNN_NUM_NEURONS; i++) begin
                if (membrane[i] > membrane_t'(leak_rate)) begin
                    membrane[i] <= membrane[i] - membrane_t'(leak_rate);
                end else begin
                    membrane[i] <= '0;
                end
                if (refrac[i] != '0) begin
                    refrac[i] <= refrac[i] - 1'b1;
                end
            end
        end else if (fire_valid) begin
            membrane[syn_event_neuron] <= '0;
            refrac[syn_event_neuron]   <= refrac_period;
        end else if (event_live) begin
            membrane[syn_event_neuron] <= next_mem;
        end
    end

    // One count per id written to the queue
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || snn_soft_reset) begin
            spike_count <= '0;
        end else if (fire_valid) begin
            spike_count <= spike_count + 1'b1;
        end
    end

endmodule

// File: rtl/spike_out_fifo.sv
//--------------------------------------
// Output spike queue
// Circular buffer of fired neuron ids,
// drained in firing order
//--------------------------------------
`timescale 1ns/1ps
`include "snn_defines.svh"

module spike_out_fifo (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                snn_soft_reset,
    input  logic                fire_valid,
    input  snn_pkg::neuron_id_t fire_neuron,
    output logic                fifo_full,
    output logic                spike_out_valid,
    output snn_pkg::neuron_id_t spike_out_neuron,
    input  logic                spike_out_ready
);

    import snn_pkg::*;

    localparam int DEPTH = `SNN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // Payload storage
    neuron_id_t       id_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             do_write;
    logic             do_read;

    assign do_write = fire_valid && !fifo_full;
    assign do_read  = spike_out_valid && spike_out_ready;

    always_ff @(posedge sys_clk) begin
        if (do_write) begin
            id_mem[wr_ptr] <= fire_neuron;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || snn_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + (PTR_W+1)'(do_write) - (PTR_W+1)'(do_read);
        end
    end

    assign fifo_full        = (fill == (PTR_W+1)'(DEPTH));
    assign spike_out_valid  = (fill != '0);
    assign spike_out_neuron = id_mem[rd_ptr];

endmodule

// File: rtl/status_leds.sv
//--------------------------------------
// Status LEDs
// Heartbeat, enable, busy and a spike
// activity PWM
//--------------------------------------
`timescale 1ns/1ps
`include "snn_defines.svh"

module status_leds (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  snn_enable,
    input  logic                  busy,
    input  snn_pkg::spike_count_t spike_count,
    output logic [3:0]            led
);

    logic [`SNN_HEARTBEAT_BIT:0] heartbeat_cnt;
    logic [7:0]                  pwm_cnt;

    // Free-running counters
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            heartbeat_cnt <= '0;
            pwm_cnt       <= '0;
        end else begin
            heartbeat_cnt <= heartbeat_cnt + 1'b1;
            pwm_cnt       <= pwm_cnt + 1'b1;
        end
    end

    assign led[0] = heartbeat_cnt[`SNN_HEARTBEAT_BIT];
    assign led[1] = snn_enable;
    assign led[2] = busy;
    // Duty cycle tracks the low byte of the spike count
    assign led[3] = (pwm_cnt < spike_count[7:0]);

endmodule

// File: rtl/snn_core_top.sv
//--------------------------------------
// SNN core top level
// Synapse scanner, LIF neurons, output
// queue and status LEDs
//--------------------------------------
`timescale 1ns/1ps

module snn_core_top (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    // Control levels
    input  logic                  snn_enable,
    input  logic                  snn_soft_reset,
    input  snn_pkg::membrane_t    threshold,
    input  snn_pkg::leak_t        leak_rate,
    input  snn_pkg::refrac_t      refrac_period,
    input  logic                  timestep,
    // Weight write
    input  logic                  weight_we,
    input  snn_pkg::axon_id_t     weight_axon,
    input  snn_pkg::neuron_id_t   weight_neuron,
    input  snn_pkg::weight_t      weight_data,
    // Input spike
    input  logic                  spike_in_valid,
    input  snn_pkg::axon_id_t     spike_in_axon,
    output logic                  spike_in_ready,
    // Output spike
    output logic                  spike_out_valid,
    output snn_pkg::neuron_id_t   spike_out_neuron,
    input  logic                  spike_out_ready,
    // Status
    output snn_pkg::spike_count_t spike_count,
    output logic                  busy,
    output logic [3:0]            led
);

    import snn_pkg::*;

    logic       syn_event_valid;
    neuron_id_t syn_event_neuron;
    weight_t    syn_event_weight;
    logic       syn_event_ready;
    logic       scan_busy;
    logic       fire_valid;
    neuron_id_t fire_neuron;
    logic       fifo_full;

    assign busy = scan_busy | spike_out_valid;

    synapse_array u_synapse_array (
        .sys_clk          (sys_clk),
        .sys_rst_n        (sys_rst_n),
        .snn_enable       (snn_enable),
        .snn_soft_reset   (snn_soft_reset),
        .weight_we        (weight_we),
        .weight_axon      (weight_axon),
        .weight_neuron    (weight_neuron),
        .weight_data      (weight_data),
        .spike_in_valid   (spike_in_valid),
        .spike_in_axon    (spike_in_axon),
        .spike_in_ready   (spike_in_ready),
        .syn_event_valid  (syn_event_valid),
        .syn_event_neuron (syn_event_neuron),
        .syn_event_weight (syn_event_weight),
        .syn_event_ready  (syn_event_ready),
        .scan_busy        (scan_busy)
    );

    lif_neuron_array u_lif_neuron_array (
        .sys_clk          (sys_clk),
        .sys_rst_n        (sys_rst_n),
        .snn_enable       (snn_enable),
        .snn_soft_reset   (snn_soft_reset),
        .timestep         (timestep),
        .threshold        (threshold),
        .leak_rate        (leak_rate),
        .refrac_period    (refrac_period),
        .syn_event_valid  (syn_event_valid),
        .syn_event_neuron (syn_event_neuron),
        .syn_event_weight (syn_event_weight),
        .syn_event_ready  (syn_event_ready),
        .fire_valid       (fire_valid),
        .fire_neuron      (fire_neuron),
        .fifo_full        (fifo_full),
        .spike_count      (spike_count)
    );

    spike_out_fifo u_spike_out_fifo (
        .sys_clk          (sys_clk),
        .sys_rst_n        (sys_rst_n),
        .snn_soft_reset   (snn_soft_reset),
        .fire_valid       (fire_valid),
        .fire_neuron      (fire_neuron),
        .fifo_full        (fifo_full),
        .spike_out_valid  (spike_out_valid),
        .spike_out_neuron (spike_out_neuron),
        .spike_out_ready  (spike_out_ready)
    );

    status_leds u_status_leds (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .snn_enable  (snn_enable),
        .busy        (busy),
        .spike_count (spike_count),
        .led         (led)
    );

endmodule

// File: bench/tb_snn_core.sv
//--------------------------------------
// SNN core testbench
// Table-driven stimulus checked against
// a reference model of the LIF neurons
//--------------------------------------
`timescale 1ns/1ps

module tb_snn_core;

    typedef enum logic [3:0] {
        op_row, op_spike, op_step, op_param, op_soft, op_hold, op_stall, op_off, op_random
    } op_t;

    // One table entry with its operation and arguments
    typedef struct packed {
        op_t         op;
        logic [3:0]  a;
        logic [15:0] b;
        logic [15:0] c;
    } step_t;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        snn_enable;
    logic        snn_soft_reset;
    logic [15:0] threshold;
    logic [7:0]  leak_rate;
    logic [3:0]  refrac_period;
    logic        timestep;
    logic        weight_we;
    logic [3:0]  weight_axon;
    logic [3:0]  weight_neuron;
    logic [7:0]  weight_data;
    logic        spike_in_valid;
    logic [3:0]  spike_in_axon;
    logic        spike_in_ready;
    logic        spike_out_valid;
    logic [3:0]  spike_out_neuron;
    logic        spike_out_ready;
    logic [31:0] spike_count;
    logic        busy;
    logic [3:0]  led;

    // Reference model state
    int          wt_m [256] = '{default: 0};
    int          mem_m [16] = '{default: 0};
    int          ref_m [16] = '{default: 0};
    int          count_m;
    int          exp_q [$];
    int          hold_left;
    logic [31:0] rng_state;
    step_t       steps [$];

    snn_core_top uut (.*);

    always #20 sys_clk = ~sys_clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_that(input bit ok, input string what);
        assert (ok) else stop_run($sformatf("Error at %0t ns: %s", $time, what));
    endtask

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic next_cycle();
        @(posedge sys_clk);
        #1;
    endtask

    //--------------------------------------
    // Reference model
    //--------------------------------------
    task automatic model_spike(input int a);
        int s;
        for (int n = 0; n < 16; n++) begin
            if (wt_m[a*16+n] != 0 && ref_m[n] == 0) begin
                s = mem_m[n] + wt_m[a*16+n];
                s = (s < 0) ? 0 : ((s > 65535) ? 65535 : s);
                if (s >= threshold) begin
                    exp_q.push_back(n);
                    count_m++;
                    mem_m[n] = 0;
                    ref_m[n] = refrac_period;
                end else begin
                    mem_m[n] = s;
                end
            end
        end
    endtask

    task automatic model_leak();
        for (int n = 0; n < 16; n++) begin
            mem_m[n] = (mem_m[n] > leak_rate) ? mem_m[n] - leak_rate : 0;
            if (ref_m[n] > 0) ref_m[n]--;
        end
    endtask

    //--------------------------------------
    // Drivers
    //--------------------------------------
    // Also settles the expected ids and count of all earlier spikes
    task automatic wait_idle();
        int t;
        t = 0;
        while (busy) begin
            if (t == 1000) stop_run("Timeout: the core stayed busy for 1000 cycles");
            next_cycle();
            t++;
        end
        check_that(exp_q.size() == 0, $sformatf("%0d predicted spikes missing", exp_q.size()));
        check_that(spike_count == count_m,
                   $sformatf("spike_count %0d, expected %0d", spike_count, count_m));
    endtask

    task automatic write_row(input logic [3:0] a, input logic [15:0] mask, input logic [7:0] w);
        wait_idle();
        for (int n = 0; n < 16; n++) begin
            if (mask[n]) begin
                weight_we     = 1'b1;
                weight_axon   = a;
                weight_neuron = n;
                weight_data   = w;
                wt_m[a*16+n]  = int'($signed(w));
                next_cycle();
            end
        end
        weight_we = 1'b0;
    endtask

    task automatic send_spike(input logic [3:0] a);
        int t;
        model_spike(a);
        spike_in_valid = 1'b1;
        spike_in_axon  = a;
        t = 0;
        while (!spike_in_ready) begin
            if (t == 400) stop_run("Timeout: spike_in_ready did not return within 400 cycles");
            next_cycle();
            t++;
        end
        next_cycle();
        spike_in_valid = 1'b0;
    endtask

    task automatic pulse_timestep();
        wait_idle();
        timestep = 1'b1;
        next_cycle();
        timestep = 1'b0;
        model_leak();
    endtask

    task automatic pulse_soft_reset();
        wait_idle();
        snn_soft_reset = 1'b1;
        next_cycle();
        snn_soft_reset = 1'b0;
        mem_m   = '{default: 0};
        ref_m   = '{default: 0};
        count_m = 0;
        check_that(spike_count == 0 && !spike_out_valid && !busy && !led[2] && !led[3],
                   "status not cleared by soft reset");
    endtask

    // Offer a spike for 20 cycles with the core disabled
    task automatic offer_disabled();
        wait_idle();
        snn_enable     = 1'b0;
        spike_in_valid = 1'b1;
        spike_in_axon  = 4'd0;
        repeat (20) begin
            next_cycle();
            check_that(!spike_in_ready && !led[1], "spike_in_ready or led[1] high while disabled");
        end
        spike_in_valid = 1'b0;
        snn_enable     = 1'b1;
    endtask

    task automatic random_phase(input int count);
        logic [31:0] r;
        int          t;
        for (int k = 0; k < count; k++) begin
            r = next_rand();
            case (r[1:0])
                2'd0:    write_row(r[7:4], 16'h1 << r[11:8], 8'(r[23:16] % 90) - 8'd20);
                2'd3:    pulse_timestep();
                default: send_spike(r[7:4]);
            endcase
        end
        wait_idle();
        // PWM should light within one full counter period
        if (count_m % 256 != 0) begin
            t = 0;
            while (!led[3] && t < 256) begin
                next_cycle();
                t++;
            end
            check_that(led[3], "led[3] never high with a nonzero spike count");
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            op_row:    write_row(s.a, s.b, s.c[7:0]);
            op_spike:  send_spike(s.a);
            op_step:   pulse_timestep();
            op_param: begin
                wait_idle();
                refrac_period = s.a;
                leak_rate     = s.b[7:0];
                threshold     = s.c;
            end
            op_soft:   pulse_soft_reset();
            op_hold: begin
                spike_out_ready = 1'b0;
                hold_left       = s.b;
            end
            op_stall: begin
                repeat (s.b) next_cycle();
                check_that(!spike_in_ready && busy && led[2:1] == 2'b11,
                           "spike_in_ready high or status low under back-pressure");
            end
            op_off:    offer_disabled();
            op_random: random_phase(s.b);
            default:   stop_run("Unknown operation in the stimulus table");
        endcase
    endtask

    task automatic add_step(input op_t op, input int a, input int b, input int c);
        steps.push_back(step_t'{op, a[3:0], b[15:0], c[15:0]});
    endtask

    // Compare each output transfer with the oldest predicted id
    always @(posedge sys_clk) begin
        if (sys_rst_n && spike_out_valid && spike_out_ready) begin
            check_that(exp_q.size() > 0, "spike emitted with none predicted");
            check_that(spike_out_neuron == exp_q[0],
                       $sformatf("spike id %0d, expected %0d", spike_out_neuron, exp_q[0]));
            void'(exp_q.pop_front());
        end
    end

    // Release the output after a hold
    always @(posedge sys_clk) begin
        if (hold_left > 0) begin
            hold_left <= hold_left - 1;
            if (hold_left == 1) spike_out_ready <= #1 1'b1;
        end
    end

    initial begin
        int t;
        sys_clk         = 1'b0;
        sys_rst_n       = 1'b0;
        snn_enable      = 1'b0;
        snn_soft_reset  = 1'b0;
        threshold       = 16'd100;
        leak_rate       = 8'd10;
        refrac_period   = 4'd2;
        timestep        = 1'b0;
        weight_we       = 1'b0;
        weight_axon     = '0;
        weight_neuron   = '0;
        weight_data     = '0;
        spike_in_valid  = 1'b0;
        spike_in_axon   = '0;
        spike_out_ready = 1'b1;
        hold_left       = 0;
        count_m         = 0;
        rng_state       = 32'he931_cca1;
        repeat (4) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
        check_that(!spike_out_valid && !busy && led == 4'b0000 && spike_count == 0 &&
                   !spike_in_ready, "outputs not cleared by reset");
        t = 0;
        while (!led[0] && t < 2100) begin
            next_cycle();
            t++;
        end
        check_that(led[0], "heartbeat led[0] did not toggle");
        snn_enable = 1'b1;

        // One spike reaches threshold
        add_step(op_row, 0, 16'h00f0, 120);
        add_step(op_spike, 0, 0, 0);
        add_step(op_row, 1, 16'h8001, 100);
        add_step(op_spike, 1, 0, 0);
        // Leak between spikes and events dropped while refractory
        add_step(op_row, 2, 16'h0f00, 40);
        add_step(op_spike, 2, 0, 0);
        add_step(op_spike, 2, 0, 0);
        add_step(op_step, 0, 0, 0);
        add_step(op_spike, 2, 0, 0);
        add_step(op_spike, 2, 0, 0);
        add_step(op_step, 0, 0, 0);
        add_step(op_spike, 2, 0, 0);
        add_step(op_spike, 2, 0, 0);
        add_step(op_row, 3, 16'h0003, 55);
        add_step(op_spike, 3, 0, 0);
        add_step(op_step, 0, 0, 0);
        add_step(op_step, 0, 0, 0);
        add_step(op_spike, 3, 0, 0);
        // Back-pressure from a held output
        add_step(op_param, 0, 10, 100);
        add_step(op_step, 0, 0, 0);
        add_step(op_step, 0, 0, 0);
        add_step(op_row, 4, 16'h0fff, 127);
        add_step(op_row, 5, 16'hf000, 127);
        add_step(op_hold, 0, 40, 0);
        add_step(op_spike, 4, 0, 0);
        add_step(op_stall, 0, 20, 0);
        add_step(op_spike, 5, 0, 0);
        // Charge neurons 0 and 1 and offer a spike to the disabled core
        add_step(op_spike, 3, 0, 0);
        add_step(op_off, 0, 0, 0);
        // Soft reset clears the charge and keeps the weights
        add_step(op_soft, 0, 0, 0);
        add_step(op_spike, 0, 0, 0);
        add_step(op_spike, 3, 0, 0);
        add_step(op_random, 0, 60, 0);

        foreach (steps[i]) apply_step(steps[i]);
        wait_idle();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/snn_pkg.sv
rtl/synapse_array.sv
rtl/lif_neuron_array.sv
rtl/spike_out_fifo.sv
rtl/status_leds.sv
rtl/snn_core_top.sv
bench/tb_snn_core.sv
